// ==== vlog.f ====
hw/game_pkg.sv
hw/display_pkg.sv
hw/bid_entry.sv
hw/hold_timer.sv
hw/game_control.sv
hw/score_keeper.sv
hw/score_display.sv
hw/bidding_game_top.sv
verif/clock_gen.sv
verif/tb_bidding_game.sv

// ==== run.sh ====
#!/bin/sh
# build and run the bidding game testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bidding_game -f vlog.f \
    && ./obj_dir/Vtb_bidding_game > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qxF "=== PASS ===" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== verif/tb_bidding_game.sv ====
`timescale 1ns/1ps

module tb_bidding_game
    import game_pkg::*;
    import display_pkg::*;
();

    localparam int rounds = 7;
    localparam int wait_limit = 400;

    // per round the p1 tens and ones presses, the p2 tens and ones presses
    // and the winner code (0 p2, 1 p1, 2 tie)
    localparam int round_table [rounds][5] = '{
        '{7, 3, 1, 12, 1},
        '{0, 5, 0, 5, 2},
        '{0, 3, 1, 0, 0},
        '{4, 0, 0, 4, 1},
        '{0, 1, 0, 2, 0},
        '{0, 0, 0, 10, 2},
        '{0, 9, 0, 1, 0}
    };

    logic Clock;
    logic resetn;
    logic key_go;
    logic key_ones;
    logic key_tens;
    logic [9:0] led;
    seg_t hex0;
    seg_t hex1;
    seg_t hex2;
    seg_t hex3;

    integer seed = 36652;
    int errors = 0;
    int exp_points [2];
    int exp_wins [2];
    int leader;
    logic game_done = 1'b0;

    clock_gen clocks (
        .Clock  (Clock),
        .resetn (resetn)
    );

    bidding_game_top #(
        .hold_cycles (28'd50)
    ) dut (
        .Clock    (Clock),
        .resetn   (resetn),
        .key_go   (key_go),
        .key_ones (key_ones),
        .key_tens (key_tens),
        .led      (led),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3)
    );

    function automatic logic [9:0] led_bit(input int pos);
        return 10'b1 << pos;
    endfunction

    task automatic reset_model();
        exp_points[0] = start_points;
        exp_points[1] = start_points;
        exp_wins[0] = 0;
        exp_wins[1] = 0;
        leader = 0;
    endtask

    // 0 go, 1 ones, 2 tens
    task automatic set_key(input int which, input logic level);
        case (which)
            0: key_go = level;
            1: key_ones = level;
            default: key_tens = level;
        endcase
    endtask

    task automatic press_key(input int which, input int count);
        int gap;
        repeat (count) begin
            gap = 1 + ({$random(seed)} % 3);
            @(posedge Clock);
            #2 set_key(which, 1'b0);
            repeat (gap) @(posedge Clock);
            #2 set_key(which, 1'b1);
            gap = 1 + ({$random(seed)} % 3);
            repeat (gap) @(posedge Clock);
        end
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (resetn !== 1'b1 && cycles < wait_limit) begin
            @(negedge Clock);
            cycles++;
        end
        assert (resetn === 1'b1) else begin
            errors++;
            $display("reset was never released");
        end
    endtask

    task automatic wait_for_led(input logic [9:0] expected, input string what);
        int cycles;
        cycles = 0;
        @(negedge Clock);
        while (led !== expected && cycles < wait_limit) begin
            @(negedge Clock);
            cycles++;
        end
        assert (led === expected) else begin
            errors++;
            $display("timed out: led never showed %b for %s, it reads %b",
                expected, what, led);
        end
    endtask

    task automatic wait_for_digits(input int tens, input int ones, input string what);
        int cycles;
        cycles = 0;
        @(negedge Clock);
        while ((hex1 !== seg_digits[tens] || hex0 !== seg_digits[ones])
                && cycles < wait_limit) begin
            @(negedge Clock);
            cycles++;
        end
        assert (hex1 === seg_digits[tens] && hex0 === seg_digits[ones]) else begin
            errors++;
            $display("ERROR %s: expected %b %b, actual %b %b",
                what, seg_digits[tens], seg_digits[ones], hex1, hex0);
        end
    endtask

    // hex outputs are registered, so look one cycle later
    task automatic check_points(input int player, input string what);
        seg_t exp_tens;
        seg_t exp_ones;
        exp_tens = seg_digits[exp_points[player] / 10];
        exp_ones = seg_digits[exp_points[player] % 10];
        @(negedge Clock);
        assert (hex3 === exp_tens && hex2 === exp_ones) else begin
            errors++;
            $display("ERROR %s: expected %b %b, actual %b %b",
                what, exp_tens, exp_ones, hex3, hex2);
        end
    endtask

    task automatic check_idle(input string what);
        assert (led === 10'b0) else begin
            errors++;
            $display("ERROR %s led: expected %b, actual %b", what, 10'b0, led);
        end
        check_points(0, {what, " points"});
        assert (hex1 === seg_blank && hex0 === seg_blank) else begin
            errors++;
            $display("ERROR %s entry digits: expected %b %b, actual %b %b",
                what, seg_blank, seg_blank, hex1, hex0);
        end
    endtask

    task automatic enter_bid(input int r, input int player);
        int tens_presses;
        int ones_presses;
        int bid;
        string name;
        tens_presses = round_table[r][2 * player];
        ones_presses = round_table[r][2 * player + 1];
        name = $sformatf("round %0d p%0d", r + 1, player + 1);
        wait_for_led(led_bit(player == 0 ? led_p1_turn : led_p2_turn), {name, " turn"});
        check_points(player, {name, " points"});
        press_key(2, tens_presses);
        press_key(1, ones_presses);
        // tens wrap past 4, ones past 9
        wait_for_digits(tens_presses % 5, ones_presses % 10, {name, " digits"});
        press_key(0, 1);
        bid = (tens_presses % 5) * 10 + (ones_presses % 10);
        if (bid > exp_points[player]) begin
            bid = exp_points[player];
        end
        exp_points[player] -= bid;
    endtask

    task automatic play_round(input int r);
        result_t winner;
        string name;
        name = $sformatf("round %0d", r + 1);
        winner = result_t'(round_table[r][4]);
        enter_bid(r, leader);
        enter_bid(r, 1 - leader);
        wait_for_led(led_bit(led_compare), {name, " compare"});
        wait_for_led(led_bit(winner == result_p1 ? led_round_p1 : led_round_p2),
            {name, " result"});
        check_points(leader, {name, " points in hold"});
        if (winner != result_p2) begin
            exp_wins[0]++;
        end
        if (winner != result_p1) begin
            exp_wins[1]++;
        end
        // ties and player two wins hand the lead to player two
        leader = (winner == result_p1) ? 0 : 1;
        if (exp_wins[0] >= 5 || exp_wins[1] >= 5) begin
            wait_for_led(led_bit(exp_wins[0] >= 5 ? led_game_p1 : led_game_p2),
                {name, " game over"});
            assert (r == rounds - 1) else begin
                errors++;
                $display("the game ended after round %0d, before the last table row", r + 1);
            end
            reset_model();
            wait_for_led(10'b0, "idle after game over");
            check_idle("idle after game over");
            game_done = 1'b1;
        end
    endtask

    initial begin
        key_go = 1'b1;
        key_ones = 1'b1;
        key_tens = 1'b1;
        reset_model();
        wait_for_reset();
        check_idle("after reset");
        press_key(0, 1);
        for (int r = 0; r < rounds && !game_done; r++) begin
            play_round(r);
        end
        assert (game_done) else begin
            errors++;
            $display("the game did not end after the last table row");
        end
        // a new game is led by player one with both scores restored
        press_key(0, 1);
        wait_for_led(led_bit(led_p1_turn), "new game turn");
        check_points(0, "new game p1 points");
        press_key(0, 1);
        wait_for_led(led_bit(led_p2_turn), "new game p2 turn");
        check_points(1, "new game p2 points");
        press_key(0, 1);
        // a tie of zero bids must not end the game once the counts are cleared
        wait_for_led(led_bit(led_round_p2), "new game tie");
        wait_for_led(led_bit(led_p2_turn), "new game next turn");
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verif/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int reset_cycles = 16
) (
    output logic Clock,
    output logic resetn
);

    // 20 ns period
    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge Clock);
        #2 resetn = 1'b1;
    end

endmodule

// ==== hw/bidding_game_top.sv ====
`timescale 1ns/1ps

module bidding_game_top
    import game_pkg::*;
    import display_pkg::*;
#(
    parameter hold_count_t hold_cycles = default_hold_cycles
) (
    input  logic       Clock,
    input  logic       resetn,
    input  logic       key_go,
    input  logic       key_ones,
    input  logic       key_tens,
    output logic [9:0] led,
    output seg_t       hex0,
    output seg_t       hex1,
    output seg_t       hex2,
    output seg_t       hex3
);

    logic go_press;
    logic go_release;
    logic entry_enable;
    logic load_bid;
    logic bid_player;
    logic compare;
    logic new_game;
    logic hold_run;
    logic hold_done;
    logic show_player;
    logic p1_game_won;
    logic p2_game_won;
    digit_t bid_ones;
    digit_t bid_tens;
    points_t bid_value;
    points_t p1_points;
    points_t p2_points;
    result_t round_result;

    bid_entry u_bid_entry (
        .Clock        (Clock),
        .resetn       (resetn),
        .key_go       (key_go),
        .key_ones     (key_ones),
        .key_tens     (key_tens),
        .entry_enable (entry_enable),
        .clear        (load_bid),
        .go_press     (go_press),
        .go_release   (go_release),
        .bid_ones     (bid_ones),
        .bid_tens     (bid_tens),
        .bid_value    (bid_value)
    );

    game_control u_game_control (
        .Clock        (Clock),
        .resetn       (resetn),
        .go_press     (go_press),
        .go_release   (go_release),
        .round_result (round_result),
        .p1_game_won  (p1_game_won),
        .p2_game_won  (p2_game_won),
        .hold_done    (hold_done),
        .entry_enable (entry_enable),
        .load_bid     (load_bid),
        .bid_player   (bid_player),
        .compare      (compare),
        .new_game     (new_game),
        .hold_run     (hold_run),
        .show_player  (show_player),
        .led          (led)
    );

    score_keeper u_score_keeper (
        .Clock        (Clock),
        .resetn       (resetn),
        .load_bid     (load_bid),
        .bid_player   (bid_player),
        .bid_value    (bid_value),
        .compare      (compare),
        .new_game     (new_game),
        .round_result (round_result),
        .p1_points    (p1_points),
        .p2_points    (p2_points),
        .p1_game_won  (p1_game_won),
        .p2_game_won  (p2_game_won)
    );

    hold_timer #(
        .hold_count_limit (hold_cycles)
    ) u_hold_timer (
        .Clock  (Clock),
        .resetn (resetn),
        .run    (hold_run),
        .done   (hold_done)
    );

    score_display u_score_display (
        .Clock        (Clock),
        .resetn       (resetn),
        .show_player  (show_player),
        .entry_enable (entry_enable),
        .bid_ones     (bid_ones),
        .bid_tens     (bid_tens),
        .p1_points    (p1_points),
        .p2_points    (p2_points),
        .hex0         (hex0),
        .hex1         (hex1),
        .hex2         (hex2),
        .hex3         (hex3)
    );

endmodule

// ==== hw/score_display.sv ====
`timescale 1ns/1ps

module score_display
    import game_pkg::*;
    import display_pkg::*;
(
    input  logic    Clock,
    input  logic    resetn,
    input  logic    show_player,
    input  logic    entry_enable,
    input  digit_t  bid_ones,
    input  digit_t  bid_tens,
    input  points_t p1_points,
    input  points_t p2_points,
    output seg_t    hex0,
    output seg_t    hex1,
    output seg_t    hex2,
    output seg_t    hex3
);

    points_t shown_points;
    digit_t points_ones;
    digit_t points_tens;

    function automatic seg_t to_seg(input digit_t value);
        return (value <= 4'd9) ? seg_digits[value] : seg_blank;
    endfunction

    assign shown_points = show_player ? p2_points : p1_points;
    assign points_ones = digit_t'(shown_points % 6'd10);
    assign points_tens = digit_t'(shown_points / 6'd10);

    always_ff @(posedge Clock) begin
        if (!resetn) begin
            hex0 <= seg_blank;
            hex1 <= seg_blank;
            hex2 <= seg_blank;
            hex3 <= seg_blank;
        end else begin
            // entry digits only while a bid is being keyed
            hex0 <= entry_enable ? to_seg(bid_ones) : seg_blank;
            hex1 <= entry_enable ? to_seg(bid_tens) : seg_blank;
            hex2 <= to_seg(points_ones);
            hex3 <= to_seg(points_tens);
        end
    end

endmodule

// ==== hw/score_keeper.sv ====
`timescale 1ns/1ps

module score_keeper
    import game_pkg::*;
(
    input  logic    Clock,
    input  logic    resetn,
    input  logic    load_bid,
    input  logic    bid_player,
    input  points_t bid_value,
    input  logic    compare,
    input  logic    new_game,
    output result_t round_result,
    output points_t p1_points,
    output points_t p2_points,
    output logic    p1_game_won,
    output logic    p2_game_won
);

    points_t p1_bid;
    points_t p2_bid;
    points_t own_points;
    points_t bid_cut;
    win_count_t p1_wins;
    win_count_t p2_wins;

    // a bid cannot spend more than the bidder has left
    assign own_points = bid_player ? p2_points : p1_points;
    assign bid_cut = (bid_value > own_points) ? own_points : bid_value;

    always_ff @(posedge Clock) begin
        if (load_bid) begin
            if (bid_player) begin
                p2_bid <= bid_cut;
            end else begin
                p1_bid <= bid_cut;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (!resetn || new_game) begin
            p1_points <= start_points;
            p2_points <= start_points;
            p1_wins <= '0;
            p2_wins <= '0;
            round_result <= result_p2;
        end else if (load_bid) begin
            if (bid_player) begin
                p2_points <= p2_points - bid_cut;
            end else begin
                p1_points <= p1_points - bid_cut;
            end
        end else if (compare) begin
            if (p1_bid > p2_bid) begin
                round_result <= result_p1;
                p1_wins <= p1_wins + 3'd1;
            end else if (p1_bid < p2_bid) begin
                round_result <= result_p2;
                p2_wins <= p2_wins + 3'd1;
            end else begin
                // tie scores a round for both
                round_result <= result_tie;
                p1_wins <= p1_wins + 3'd1;
                p2_wins <= p2_wins + 3'd1;
            end
        end
    end

    assign p1_game_won = (p1_wins == wins_to_finish);
    assign p2_game_won = (p2_wins == wins_to_finish);

    // the game ends before any count passes the limit
    win_limit_a: assert property (@(posedge Clock) disable iff (!resetn)
        (p1_wins <= wins_to_finish) && (p2_wins <= wins_to_finish));

endmodule

// ==== hw/game_control.sv ====
`timescale 1ns/1ps

module game_control
    import game_pkg::*;
    import display_pkg::*;
(
    input  logic       Clock,
    input  logic       resetn,
    input  logic       go_press,
    input  logic       go_release,
    input  result_t    round_result,
    input  logic       p1_game_won,
    input  logic       p2_game_won,
    input  logic       hold_done,
    output logic       entry_enable,
    output logic       load_bid,
    output logic       bid_player,
    output logic       compare,
    output logic       new_game,
    output logic       hold_run,
    output logic       show_player,
    output logic [9:0] led
);

    game_state_t state;
    game_state_t next_state;
    // 0 while player one leads
    logic leader;
    logic second_turn;
    logic releasing;

    always_comb begin
        next_state = state;
        case (state)
            s_idle:           if (go_press) next_state = s_idle_release;
            s_idle_release:   if (go_release) next_state = s_first_bid;
            s_first_bid:      if (go_press) next_state = s_first_release;
            // leave once the bid has been loaded
            s_first_release:  if (load_bid) next_state = s_second_bid;
            s_second_bid:     if (go_press) next_state = s_second_release;
            s_second_release: if (load_bid) next_state = s_compare;
            s_compare:        next_state = s_round_hold;
            s_round_hold: begin
                if (hold_done) begin
                    next_state = (p1_game_won || p2_game_won) ? s_game_over : s_first_bid;
                end
            end
            s_game_over:      if (hold_done) next_state = s_idle;
            default:          next_state = s_idle;
        endcase
    end

    assign releasing = (state == s_first_release) || (state == s_second_release);

    always_ff @(posedge Clock) begin
        if (!resetn) begin
            state <= s_idle;
            load_bid <= 1'b0;
            leader <= 1'b0;
        end else begin
            state <= next_state;
            load_bid <= go_release && releasing;
            if (new_game) begin
                leader <= 1'b0;
            end else if (state == s_round_hold && hold_done) begin
                // ties and player two wins hand the lead to player two
                leader <= (round_result != result_p1);
            end
        end
    end

    assign second_turn = (state == s_second_bid) || (state == s_second_release);
    assign entry_enable = (state == s_first_bid) || (state == s_first_release) || second_turn;
    assign bid_player = leader ^ second_turn;
    assign show_player = bid_player;
    assign compare = (state == s_compare);
    assign hold_run = (state == s_round_hold) || (state == s_game_over);
    assign new_game = (state == s_game_over) && hold_done;

    always_comb begin
        led = '0;
        if (entry_enable) begin
            led[bid_player ? led_p2_turn : led_p1_turn] = 1'b1;
        end
        case (state)
            s_compare:    led[led_compare] = 1'b1;
            s_round_hold: led[(round_result == result_p1) ? led_round_p1 : led_round_p2] = 1'b1;
            s_game_over:  led[p1_game_won ? led_game_p1 : led_game_p2] = 1'b1;
            default:      ;
        endcase
    end

    // a bid is never loaded in the compare cycle
    load_compare_a: assert property (@(posedge Clock) disable iff (!resetn)
        !(load_bid && compare));

endmodule

// ==== hw/hold_timer.sv ====
`timescale 1ns/1ps

module hold_timer #(
    parameter int unsigned hold_count_limit = 16
) (
    input  logic Clock,
    input  logic resetn,
    input  logic run,
    output logic done
);

    localparam int unsigned count_width = $clog2(hold_count_limit + 1);
    localparam logic [count_width-1:0] last_count = count_width'(hold_count_limit - 1);

    logic [count_width-1:0] count;

    // ends on the last cycle of the interval
    assign done = run && (count == last_count);

    always_ff @(posedge Clock) begin
        if (!resetn || !run || done) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== hw/bid_entry.sv ====
`timescale 1ns/1ps

module bid_entry
    import game_pkg::*;
(
    input  logic    Clock,
    input  logic    resetn,
    input  logic    key_go,
    input  logic    key_ones,
    input  logic    key_tens,
    input  logic    entry_enable,
    input  logic    clear,
    output logic    go_press,
    output logic    go_release,
    output digit_t  bid_ones,
    output digit_t  bid_tens,
    output points_t bid_value
);

    // bit 0 go, bit 1 ones, bit 2 tens
    logic [2:0] sync_a;
    logic [2:0] sync_b;
    logic [2:0] key_last;
    logic [2:0] fall;
    logic [2:0] rise;

    // keys idle high, so a press is a falling edge
    assign fall = key_last & ~sync_b;
    assign rise = ~key_last & sync_b;

    always_ff @(posedge Clock) begin
        if (!resetn) begin
            sync_a <= 3'b111;
            sync_b <= 3'b111;
            key_last <= 3'b111;
            go_press <= 1'b0;
            go_release <= 1'b0;
        end else begin
            sync_a <= {key_tens, key_ones, key_go};
            sync_b <= sync_a;
            key_last <= sync_b;
            go_press <= fall[0];
            go_release <= rise[0];
        end
    end

    always_ff @(posedge Clock) begin
        if (!resetn || clear) begin
            bid_ones <= '0;
            bid_tens <= '0;
        end else if (entry_enable) begin
            if (fall[1]) begin
                bid_ones <= (bid_ones == max_ones) ? '0 : bid_ones + 4'd1;
            end
            if (fall[2]) begin
                bid_tens <= (bid_tens == max_tens) ? '0 : bid_tens + 4'd1;
            end
        end
    end

    assign bid_value = points_t'(bid_tens) * 6'd10 + points_t'(bid_ones);

    // wrap keeps both digits inside their range
    digit_range_a: assert property (@(posedge Clock) disable iff (!resetn)
        (bid_ones <= max_ones) && (bid_tens <= max_tens));

endmodule

// ==== hw/display_pkg.sv ====
package display_pkg;

    // active-low segments, bit 6 is segment g
    typedef logic [6:0] seg_t;

    localparam seg_t seg_blank = 7'b111_1111;

    // decimal digits 0 to 9
    localparam seg_t seg_digits [10] = '{
        7'b100_0000,
        7'b111_1001,
        7'b010_0100,
        7'b011_0000,
        7'b001_1001,
        7'b001_0010,
        7'b000_0010,
        7'b111_1000,
        7'b000_0000,
        7'b001_1000
    };

    // positions on the 10-bit led bus
    localparam int led_p1_turn = 0;
    localparam int led_p2_turn = 1;
    localparam int led_compare = 4;
    localparam int led_game_p2 = 6;
    localparam int led_game_p1 = 7;
    localparam int led_round_p2 = 8;
    localparam int led_round_p1 = 9;

endpackage

// ==== hw/game_pkg.sv ====
package game_pkg;

    // remaining points or a bid
    typedef logic [5:0] points_t;

    // one decimal digit
    typedef logic [3:0] digit_t;

    // rounds won by one player
    typedef logic [2:0] win_count_t;

    // hold interval counter
    typedef logic [27:0] hold_count_t;

    // round outcome
    typedef logic [1:0] result_t;

    localparam result_t result_p2 = 2'd0;
    localparam result_t result_p1 = 2'd1;
    localparam result_t result_tie = 2'd2;

    typedef enum logic [3:0] {
        s_idle,
        s_idle_release,
        s_first_bid,
        s_first_release,
        s_second_bid,
        s_second_release,
        s_compare,
        s_round_hold,
        s_game_over
    } game_state_t;

    localparam points_t start_points = 6'd49;
    localparam digit_t max_tens = 4'd4;
    localparam digit_t max_ones = 4'd9;
    localparam win_count_t wins_to_finish = 3'd5;

    // three seconds at 50 MHz
    localparam hold_count_t default_hold_cycles = 28'd150_000_000;

endpackage
